//--- design/ads1115_reader.sv
`timescale 1ns/1ns

module ads1115_reader import ads_pkg::*; #(
    parameter int CONV_WAIT_TICKS = 1800,  // Ticks after config before the pointer write
    parameter int READ_GAP_TICKS  = 2000   // Ticks between consecutive reads
) (
    input  logic        i2c_sclk_local_200khz,
    input  logic        reset_n,
    output logic        scl,
    output logic        sda_out_en,
    output logic        sda_out,
    input  logic        sda_in,
    output logic [15:0] lux_value,
    output logic        lux_valid
);

    i2c_cmd_t    cmd;
    logic        cmd_valid;
    logic        busy;
    logic        done;
    i2c_result_t rx;

    // ------------------------------
    // Transaction order and timing
    // ------------------------------
    ads_sequencer #(
        .CONV_WAIT_TICKS (CONV_WAIT_TICKS),
        .READ_GAP_TICKS  (READ_GAP_TICKS)
    ) seq_i (
        .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
        .reset_n               (reset_n),
        .cmd                   (cmd),
        .cmd_valid             (cmd_valid),
        .busy                  (busy),
        .done                  (done),
        .rx                    (rx),
        .lux_value             (lux_value),
        .lux_valid             (lux_valid)
    );

    // Bit level SCL/SDA generation
    i2c_byte_engine engine_i (
        .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
        .reset_n               (reset_n),
        .cmd                   (cmd),
        .cmd_valid             (cmd_valid),
        .busy                  (busy),
        .done                  (done),
        .rx                    (rx),
        .scl                   (scl),
        .sda_out_en            (sda_out_en),
        .sda_out               (sda_out),
        .sda_in                (sda_in)
    );

endmodule

//--- design/ads_pkg.sv
package ads_pkg;

    // ------------------------------
    // ADS1115 addressing
    // ------------------------------
    localparam logic [6:0] ADS_ADDR   = 7'h48;   // ADDR pin tied to GND
    localparam logic [7:0] PTR_CONV   = 8'h00;   // Conversion result register
    localparam logic [7:0] PTR_CONFIG = 8'h01;   // Config register

    // Single-shot start, AIN0 vs GND, +/-2.048 V range, single-shot mode
    localparam logic [7:0] CONFIG_MSB = 8'hC5;
    // 128 SPS, comparator disabled
    localparam logic [7:0] CONFIG_LSB = 8'h83;

    // ------------------------------
    // Byte engine command interface
    // ------------------------------
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } i2c_op_t;

    // One bus operation handed to the byte engine
    typedef struct packed {
        i2c_op_t    op;
        logic [7:0] data;         // Byte shifted out on OP_WRITE
        logic       master_nack;  // OP_READ only, 1 = NACK after the byte
    } i2c_cmd_t;

    // Returned on done
    typedef struct packed {
        logic [7:0] data;         // Byte collected on OP_READ
        logic       ack_seen;     // SDA low in the acknowledge slot
    } i2c_result_t;

    // Transaction headers
    localparam logic [7:0] ADDR_WR = {ADS_ADDR, 1'b0};  // 0x90
    localparam logic [7:0] ADDR_RD = {ADS_ADDR, 1'b1};  // 0x91

endpackage

//--- design/ads_sequencer.sv
`timescale 1ns/1ns

module ads_sequencer import ads_pkg::*; #(
    parameter int CONV_WAIT_TICKS = 1800,
    parameter int READ_GAP_TICKS  = 2000
) (
    input  logic        i2c_sclk_local_200khz,
    input  logic        reset_n,
    output i2c_cmd_t    cmd,
    output logic        cmd_valid,
    input  logic        busy,
    input  logic        done,
    input  i2c_result_t rx,
    output logic [15:0] lux_value,
    output logic        lux_valid
);

    localparam int MAX_WAIT = (CONV_WAIT_TICKS > READ_GAP_TICKS) ?
                              CONV_WAIT_TICKS : READ_GAP_TICKS;
    localparam int CNT_W    = $clog2(MAX_WAIT + 1);

    typedef enum logic [2:0] {
        PH_CONFIG,     // Write config register
        PH_CONV_WAIT,  // First conversion in progress
        PH_POINTER,    // Point at conversion register
        PH_READ,       // Two-byte read
        PH_GAP         // Idle between reads
    } phase_t;

    phase_t           phase;
    logic [2:0]       step;        // Command index within the transaction
    logic             waiting;     // Command issued, done not yet seen
    logic [CNT_W-1:0] wait_cnt;    // Shared by conversion wait and read gap
    logic [7:0]       msb_q;

    function automatic i2c_cmd_t make_cmd(input i2c_op_t op, input logic [7:0] data,
                                          input logic nack);
        i2c_cmd_t c;
        c.op          = op;
        c.data        = data;
        c.master_nack = nack;
        return c;
    endfunction

    // ------------------------------
    // Command lists
    // ------------------------------
    function automatic i2c_cmd_t step_cmd(input phase_t ph, input logic [2:0] st);
        i2c_cmd_t c;
        c = make_cmd(OP_STOP, 8'h00, 1'b1);  // Last entry of every list
        case (ph)
            PH_CONFIG: case (st)
                3'd0:    c = make_cmd(OP_START, 8'h00, 1'b1);
                3'd1:    c = make_cmd(OP_WRITE, ADDR_WR, 1'b1);
                3'd2:    c = make_cmd(OP_WRITE, PTR_CONFIG, 1'b1);
                3'd3:    c = make_cmd(OP_WRITE, CONFIG_MSB, 1'b1);
                3'd4:    c = make_cmd(OP_WRITE, CONFIG_LSB, 1'b1);
                default: ;
            endcase
            PH_POINTER: case (st)
                3'd0:    c = make_cmd(OP_START, 8'h00, 1'b1);
                3'd1:    c = make_cmd(OP_WRITE, ADDR_WR, 1'b1);
                3'd2:    c = make_cmd(OP_WRITE, PTR_CONV, 1'b1);
                default: ;
            endcase
            PH_READ: case (st)
                3'd0:    c = make_cmd(OP_START, 8'h00, 1'b1);
                3'd1:    c = make_cmd(OP_WRITE, ADDR_RD, 1'b1);
                3'd2:    c = make_cmd(OP_READ, 8'h00, 1'b0);   // MSB, master ACK
                3'd3:    c = make_cmd(OP_READ, 8'h00, 1'b1);   // LSB, master NACK
                default: ;
            endcase
            default: ;
        endcase
        return c;
    endfunction

    function automatic logic [2:0] last_step(input phase_t ph);
        case (ph)
            PH_CONFIG:  return 3'd5;
            PH_POINTER: return 3'd3;
            default:    return 3'd4;
        endcase
    endfunction

    // ------------------------------
    // Phase control
    // ------------------------------
    always_ff @(posedge i2c_sclk_local_200khz) begin
        if (!reset_n) begin
            phase     <= PH_CONFIG;
            step      <= 3'd0;
            waiting   <= 1'b0;
            wait_cnt  <= '0;
            cmd_valid <= 1'b0;
            lux_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            lux_valid <= 1'b0;
            case (phase)
                PH_CONV_WAIT, PH_GAP: begin
                    if (wait_cnt == '0) begin
                        phase <= (phase == PH_CONV_WAIT) ? PH_POINTER : PH_READ;
                        step  <= 3'd0;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                default: begin
                    if (!waiting && !busy) begin
                        cmd       <= step_cmd(phase, step);
                        cmd_valid <= 1'b1;
                        waiting   <= 1'b1;
                    end else if (done) begin
                        waiting <= 1'b0;
                        if (phase == PH_READ && step == 3'd3) begin
                            lux_value <= {msb_q, rx.data};  // Pulse lands the tick after done
                            lux_valid <= 1'b1;
                        end
                        if (step != last_step(phase)) begin
                            step <= step + 3'd1;
                        end else if (phase == PH_CONFIG) begin
                            phase    <= PH_CONV_WAIT;
                            wait_cnt <= CNT_W'(CONV_WAIT_TICKS);
                        end else if (phase == PH_POINTER) begin
                            phase <= PH_READ;  // Pointer stays put for all later reads
                            step  <= 3'd0;
                        end else begin
                            phase    <= PH_GAP;
                            wait_cnt <= CNT_W'(READ_GAP_TICKS);
                        end
                    end
                end
            endcase
        end
    end

    // High byte arrives first
    always_ff @(posedge i2c_sclk_local_200khz) begin
        if (done && phase == PH_READ && step == 3'd2)
            msb_q <= rx.data;
    end

endmodule

//--- design/i2c_byte_engine.sv
`timescale 1ns/1ns

module i2c_byte_engine import ads_pkg::*; (
    input  logic        i2c_sclk_local_200khz,
    input  logic        reset_n,
    input  i2c_cmd_t    cmd,
    input  logic        cmd_valid,
    output logic        busy,
    output logic        done,
    output i2c_result_t rx,
    output logic        scl,
    output logic        sda_out_en,
    output logic        sda_out,
    input  logic        sda_in
);

    i2c_cmd_t   cmd_q;
    logic [4:0] cnt;       // Tick within the current command
    logic [4:0] last_cnt;
    logic [7:0] sr;        // Write bits leave at [7] and read bits enter at [0]
    logic       ack_slot;
    logic       slot_scl;
    logic       slot_en;
    logic       slot_val;
    logic       hold_scl;  // Levels kept on the bus between commands
    logic       hold_en;
    logic       hold_val;

    assign last_cnt = (cmd_q.op == OP_START || cmd_q.op == OP_STOP) ? 5'd2 : 5'd17;
    assign ack_slot = (cnt >= 5'd16);
    assign done     = busy && (cnt == last_cnt);

    // ------------------------------
    // Bus levels for the current tick
    // ------------------------------
    always_comb begin
        slot_scl = 1'b1;
        slot_en  = 1'b0;
        slot_val = 1'b1;
        case (cmd_q.op)
            OP_START: begin
                slot_en  = 1'b1;
                slot_scl = (cnt != 5'd2);     // SCL drops only on the last tick
                slot_val = (cnt == 5'd0);     // SDA falls while SCL is high
            end
            OP_STOP: begin
                slot_scl = (cnt != 5'd0);
                slot_en  = (cnt != 5'd2);     // Release lets SDA rise with SCL high
                slot_val = 1'b0;
            end
            OP_WRITE: begin
                slot_scl = cnt[0];            // Even tick low and odd tick high
                slot_en  = !ack_slot;
                slot_val = sr[7];
            end
            OP_READ: begin
                slot_scl = cnt[0];
                slot_en  = ack_slot && !cmd_q.master_nack;  // Drive low only for ACK
                slot_val = 1'b0;
            end
            default: ;
        endcase
    end

    // Slot levels while running and held levels in between
    assign scl        = busy ? slot_scl : hold_scl;
    assign sda_out_en = busy ? slot_en  : hold_en;
    assign sda_out    = busy ? slot_val : hold_val;

    // Ack judged at the end of the high tick that carries done
    assign rx = '{data: sr, ack_seen: ack_slot && cnt[0] && !sda_in};

    // ------------------------------
    // Sequencing
    // ------------------------------
    always_ff @(posedge i2c_sclk_local_200khz) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            cnt      <= 5'd0;
            hold_scl <= 1'b1;
            hold_en  <= 1'b0;
            hold_val <= 1'b1;
        end else if (busy) begin
            hold_scl <= slot_scl;
            hold_en  <= slot_en;
            hold_val <= slot_val;
            if (done)
                busy <= 1'b0;
            else
                cnt <= cnt + 5'd1;
        end else if (cmd_valid) begin
            busy <= 1'b1;
            cnt  <= 5'd0;
        end
    end

    // Command latch and shift register
    always_ff @(posedge i2c_sclk_local_200khz) begin
        if (!busy && cmd_valid) begin
            cmd_q <= cmd;
            sr    <= cmd.data;
        end else if (busy && cnt[0] && !ack_slot &&
                     (cmd_q.op == OP_WRITE || cmd_q.op == OP_READ)) begin
            sr <= {sr[6:0], sda_in};  // Sample at the end of each high tick
        end
    end

endmodule

//--- files.f
design/ads_pkg.sv
design/i2c_byte_engine.sv
design/ads_sequencer.sv
design/ads1115_reader.sv
test/ads1115_slave_model.sv
test/ads1115_reader_assertions.sv
test/ads1115_reader_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module ads1115_reader_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vads1115_reader_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi
echo "Simulation finished"
exit 0

//--- test/ads1115_reader_assertions.sv
`timescale 1ns/1ns

module ads1115_reader_assertions import ads_pkg::*; (
    input logic     i2c_sclk_local_200khz,
    input logic     reset_n,
    input logic     scl,
    input logic     sda_out_en,
    input logic     sda_out,
    input logic     lux_valid,
    input i2c_cmd_t cmd
);

    logic start_stop;  // START and STOP move SDA while SCL is high
    assign start_stop = (cmd.op == OP_START) || (cmd.op == OP_STOP);

    idle_after_reset: assert property (@(posedge i2c_sclk_local_200khz)
        !reset_n |=> (scl && !sda_out_en))
        else $error("Bus not idle after reset");

    single_pulse: assert property (@(posedge i2c_sclk_local_200khz) disable iff (!reset_n)
        lux_valid |=> !lux_valid)
        else $error("lux_valid high on two consecutive ticks");

    // Data and ack bits only change while SCL is low
    sda_stable: assert property (@(posedge i2c_sclk_local_200khz) disable iff (!reset_n)
        (scl && !start_stop) |=>
            (!scl || start_stop || ($stable(sda_out_en) && $stable(sda_out))))
        else $error("SDA changed while SCL was high");

endmodule

bind ads1115_reader ads1115_reader_assertions assertions_i (
    .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
    .reset_n               (reset_n),
    .scl                   (scl),
    .sda_out_en            (sda_out_en),
    .sda_out               (sda_out),
    .lux_valid             (lux_valid),
    .cmd                   (cmd)
);

//--- test/ads1115_reader_tb.sv
`timescale 1ns/1ns

module ads1115_reader_tb import ads_pkg::*; ();

    localparam int         PERIOD    = 20;
    localparam int         CONV_WAIT = 40;
    localparam int         READ_GAP  = 30;
    localparam int         N_READS   = 6;
    localparam int         LIMIT     = (N_READS * (60 + READ_GAP) + 200 + CONV_WAIT) * 2;
    localparam logic [8:0] STOP_MARK = 9'h100;
    localparam logic [8:0] WR_BYTE   = {1'b0, ADS_ADDR, 1'b0};  // Address plus W bit
    localparam logic [8:0] RD_BYTE   = {1'b0, ADS_ADDR, 1'b1};  // Address plus R bit

    logic        i2c_sclk_local_200khz;
    logic        reset_n;
    logic        scl;
    logic        sda_out_en;
    logic        sda_out;
    logic        sda_line;
    logic        pull_low;
    logic [15:0] lux_value;
    logic        lux_valid;
    logic [15:0] read_value;
    int          read_count;
    logic [15:0] vals [N_READS];  // Slave results and expected lux_value
    logic [8:0]  exp_log [$];
    integer      seed;

    assign sda_line   = !((sda_out_en && !sda_out) || pull_low);  // Open drain with pull-up
    assign read_value = (read_count < N_READS) ? vals[read_count] : 16'h0000;

    ads1115_reader #(
        .CONV_WAIT_TICKS (CONV_WAIT),
        .READ_GAP_TICKS  (READ_GAP)
    ) dut_i (
        .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
        .reset_n               (reset_n),
        .scl                   (scl),
        .sda_out_en            (sda_out_en),
        .sda_out               (sda_out),
        .sda_in                (sda_line),
        .lux_value             (lux_value),
        .lux_valid             (lux_valid)
    );

    ads1115_slave_model slave_i (
        .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
        .scl                   (scl),
        .sda                   (sda_line),
        .read_value            (read_value),
        .pull_low              (pull_low),
        .read_count            (read_count)
    );

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Check failed: %s", what);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Timing check failed");
        end
    endtask

    initial begin
        i2c_sclk_local_200khz = 1'b0;
        forever #(PERIOD / 2) i2c_sclk_local_200khz = !i2c_sclk_local_200khz;
    end

    initial begin
        #(LIMIT * PERIOD);
        $display("Run timed out after %0d clock periods before all reads finished", LIMIT);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        seed    = 72873;
        vals    = '{16'h0000, 16'hFFFF, 16'h8001, 16'h5A5A, 16'h1234, 16'h0000};
        vals[5] = 16'($random(seed));
        reset_n = 1'b0;
        repeat (4) @(posedge i2c_sclk_local_200khz);
        #2 reset_n = 1'b1;
        @(negedge i2c_sclk_local_200khz);
        compare_hex("scl", scl, 1);
        compare_hex("sda", sda_line, 1);

        // ------------------------------
        // One pulse per read in table order
        for (int i = 0; i < N_READS; i++) begin
            do @(negedge i2c_sclk_local_200khz); while (!lux_valid);
            compare_hex("lux_value", lux_value, vals[i]);
            compare_hex("ack_log size", slave_i.ack_log.size(), 2 * (i + 1));
            compare_hex("master ack after MSB", slave_i.ack_log[2 * i], 1);
            compare_hex("master ack after LSB", slave_i.ack_log[2 * i + 1], 0);
        end
        while (read_count < N_READS) @(negedge i2c_sclk_local_200khz);

        // ------------------------------
        // Transaction log and spacing
        exp_log = '{WR_BYTE, {1'b0, PTR_CONFIG}, {1'b0, CONFIG_MSB}, {1'b0, CONFIG_LSB},
                    STOP_MARK, WR_BYTE, {1'b0, PTR_CONV}, STOP_MARK};
        repeat (N_READS) begin
            exp_log.push_back(RD_BYTE);  // No pointer write between reads
            exp_log.push_back(STOP_MARK);
        end
        compare_hex("wr_log size", slave_i.wr_log.size(), exp_log.size());
        foreach (exp_log[k])
            compare_hex($sformatf("wr_log[%0d]", k), slave_i.wr_log[k], exp_log[k]);
        require_true(slave_i.start_t[1] - slave_i.stop_t[0] >= CONV_WAIT * PERIOD,
                     "pointer write started before the conversion wait was over");
        for (int k = 1; k < N_READS; k++)
            require_true(slave_i.start_t[k + 2] - slave_i.stop_t[k + 1] >= READ_GAP * PERIOD,
                         "a read started before the gap after the previous read was over");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- test/ads1115_slave_model.sv
`timescale 1ns/1ns

module ads1115_slave_model import ads_pkg::*; (
    input  logic        i2c_sclk_local_200khz,
    input  logic        scl,
    input  logic        sda,
    input  logic [15:0] read_value,  // Result handed out on the current read
    output logic        pull_low,
    output int          read_count
);

    logic [8:0] wr_log [$];   // Received bytes, bit 8 set for a STOP
    logic       ack_log [$];  // Master acknowledge per read byte, 1 = ACK
    time        start_t [$];
    time        stop_t [$];
    logic       scl_q;
    logic       sda_q;
    logic       scl_now;
    logic       sda_now;
    logic [7:0] rx_byte;
    logic [7:0] tx_byte;
    int         bit_cnt;
    int         byte_idx;     // 0 is the address byte
    logic       rd_mode;

    initial begin
        pull_low   = 1'b0;
        read_count = 0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        bit_cnt    = 0;
        byte_idx   = 0;
        rd_mode    = 1'b0;
    end

    // Bus is looked at shortly after each tick starts
    always @(posedge i2c_sclk_local_200khz) begin
        #2;
        scl_now = scl;
        sda_now = sda;
        if (scl_q && scl_now && sda_q && !sda_now) begin          // START
            start_t.push_back($time);
            bit_cnt  = 0;
            byte_idx = 0;
            rd_mode  = 1'b0;
        end else if (scl_q && scl_now && !sda_q && sda_now) begin  // STOP
            stop_t.push_back($time);
            wr_log.push_back(9'h100);
            if (rd_mode)
                read_count++;                                       // Next table entry
            rd_mode = 1'b0;
        end else if (!scl_q && scl_now) begin
            if (bit_cnt < 8)
                rx_byte = {rx_byte[6:0], sda_now};
            else if (rd_mode && byte_idx > 0)
                ack_log.push_back(!sda_now);
            bit_cnt++;
        end else if (scl_q && !scl_now) begin
            pull_low = 1'b0;
            if (bit_cnt == 8 && !(rd_mode && byte_idx > 0)) begin
                pull_low = 1'b1;                                    // ACK every written byte
                wr_log.push_back({1'b0, rx_byte});
                rd_mode = (byte_idx == 0) && (rx_byte == ADDR_RD);
            end else if (bit_cnt >= 9) begin
                bit_cnt  = 0;
                byte_idx++;
                tx_byte  = (byte_idx == 1) ? read_value[15:8] : read_value[7:0];
                pull_low = rd_mode && (byte_idx <= 2) && !tx_byte[7];
            end else if (rd_mode && byte_idx > 0 && bit_cnt > 0 && bit_cnt < 8) begin
                pull_low = !tx_byte[7 - bit_cnt];                   // MSB first
            end
        end
        scl_q = scl_now;
        sda_q = sda_now;
    end

endmodule
